// ==== files.f ====
hw/mem_pkg.sv
hw/mem_bus_if.sv
hw/mem_wb_if.sv
hw/mem_stage.sv
hw/data_ram.sv
hw/mem_wb_reg.sv
hw/mem_subsys_top.sv
testbench/mem_stage_checker.sv
testbench/tb_mem_subsys.sv

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int ram_words    = 1024,
    parameter int ready_wait   = 1,
    parameter int read_latency = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave bus
);
    localparam int aw    = $clog2(ram_words);
    localparam int lat_w = $clog2(read_latency + 1);

    logic [mem_pkg::xlen-1:0] mem [ram_words];
    logic [aw-1:0]            word_idx;
    logic                     accept;
    logic [1:0]               busy_cnt;     // Remaining cycles with cmd_ready low
    logic [lat_w-1:0]         lat_cnt;
    logic [mem_pkg::xlen-1:0] rdata_q;

    assign word_idx = bus.addr[aw+1:2];
    assign accept   = bus.cmd_start && bus.cmd_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept && bus.cmd_write) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.wmask[i])
                    mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
    end

    // Read word sampled at acceptance and held until rdata_valid
    always_ff @(posedge clk) begin
        if (accept && !bus.cmd_write)
            rdata_q <= mem[word_idx];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Back-pressure and read latency
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (accept) begin
            busy_cnt <= 2'(ready_wait);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt <= '0;
        end else if (accept && !bus.cmd_write) begin
            lat_cnt <= lat_w'(read_latency);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    assign bus.cmd_ready   = (busy_cnt == '0);
    assign bus.rdata_valid = (lat_cnt == lat_w'(1));   // Last count of the latency
    assign bus.rdata       = rdata_q;

endmodule

`default_nettype wire

// ==== hw/mem_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if (
    input logic clk
);
    logic                     cmd_start;
    logic                     cmd_write;
    logic [mem_pkg::xlen-1:0] addr;
    logic [mem_pkg::xlen-1:0] wdata;
    logic [3:0]               wmask;      // Byte enables
    logic                     cmd_ready;
    logic [mem_pkg::xlen-1:0] rdata;
    logic                     rdata_valid;

    modport master (
        input  clk,
        output cmd_start, cmd_write, addr, wdata, wmask,
        input  cmd_ready, rdata, rdata_valid
    );

    modport slave (
        input  clk,
        input  cmd_start, cmd_write, addr, wdata, wmask,
        output cmd_ready, rdata, rdata_valid
    );
endinterface

`default_nettype wire

// ==== hw/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // Data and address width of the core
    localparam int xlen = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Memory operation carried with each instruction
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        mem_x,      // No access
        mem_lb,
        mem_lh,
        mem_lw,
        mem_lbu,
        mem_lhu,
        mem_sb,
        mem_sh,
        mem_sw
    } mem_op_t;

    // Write-back source for the register file
    typedef enum logic [1:0] {
        wb_x,
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_t;

endpackage

`default_nettype wire

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [mem_pkg::xlen-1:0] reg_pc,
    input  logic [mem_pkg::xlen-1:0] rs2_data,
    input  logic [mem_pkg::xlen-1:0] alu_out,
    input  logic [mem_pkg::xlen-1:0] br_target,
    input  logic                     br_flg,
    input  logic                     rf_wen,
    input  logic                     jmp_flg,
    input  logic                     ecall,
    input  mem_pkg::mem_op_t         mem_op,
    input  mem_pkg::wb_sel_t         wb_sel,
    input  logic [4:0]               wb_addr,
    output logic                     stall,
    mem_bus_if.master                bus,
    mem_wb_if.source                 wb
);
    typedef enum logic [1:0] {
        st_idle,
        st_wait_ready,
        st_wait_read
    } state_t;

    state_t state;
    state_t state_nx;

    // Held copy of the instruction
    logic [mem_pkg::xlen-1:0] h_reg_pc;
    logic [mem_pkg::xlen-1:0] h_rs2_data;
    logic [mem_pkg::xlen-1:0] h_alu_out;
    logic [mem_pkg::xlen-1:0] h_br_target;
    logic                     h_br_flg;
    logic                     h_rf_wen;
    logic                     h_jmp_flg;
    logic                     h_ecall;
    mem_pkg::mem_op_t         h_mem_op;
    mem_pkg::wb_sel_t         h_wb_sel;
    logic [4:0]               h_wb_addr;

    logic                     idle;
    logic                     done;
    logic                     is_store;
    logic                     is_load;
    mem_pkg::mem_op_t         cur_op;
    logic [mem_pkg::xlen-1:0] cur_addr;
    logic [mem_pkg::xlen-1:0] cur_rs2;
    logic [mem_pkg::xlen-1:0] ld_byte;
    logic [mem_pkg::xlen-1:0] ld_half;
    logic [mem_pkg::xlen-1:0] load_data;

    assign idle     = (state == st_idle);
    assign cur_op   = idle ? mem_op : h_mem_op;   // Live inputs only while idle
    assign cur_addr = idle ? alu_out : h_alu_out;
    assign cur_rs2  = idle ? rs2_data : h_rs2_data;

    assign is_store = cur_op inside {mem_pkg::mem_sb, mem_pkg::mem_sh, mem_pkg::mem_sw};
    assign is_load  = !is_store && (cur_op != mem_pkg::mem_x);

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_nx = state;
        done     = 1'b0;
        case (state)
            st_idle: begin
                done = !(is_store || is_load) || (is_store && bus.cmd_ready);
                if (is_load)
                    state_nx = bus.cmd_ready ? st_wait_read : st_wait_ready;
                else if (is_store && !bus.cmd_ready)
                    state_nx = st_wait_ready;
            end
            st_wait_ready: begin
                done = is_store && bus.cmd_ready;   // Store retires on acceptance
                if (bus.cmd_ready)
                    state_nx = is_store ? st_idle : st_wait_read;
            end
            st_wait_read: begin
                done = bus.rdata_valid;
                if (bus.rdata_valid)
                    state_nx = st_idle;
            end
            default: state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= state_nx;
    end

    always_ff @(posedge clk) begin
        if (idle) begin
            h_reg_pc    <= reg_pc;
            h_rs2_data  <= rs2_data;
            h_alu_out   <= alu_out;
            h_br_target <= br_target;
            h_br_flg    <= br_flg;
            h_rf_wen    <= rf_wen;
            h_jmp_flg   <= jmp_flg;
            h_ecall     <= ecall;
            h_mem_op    <= mem_op;
            h_wb_sel    <= wb_sel;
            h_wb_addr   <= wb_addr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus request with lane alignment
    ////////////////////////////////////////////////////////////////////////////
    assign bus.cmd_start = idle ? (is_store || is_load) : (state == st_wait_ready);
    assign bus.cmd_write = is_store;
    assign bus.addr      = cur_addr;

    always_comb begin
        case (cur_op)
            mem_pkg::mem_sb: begin
                bus.wdata = cur_rs2 << {cur_addr[1:0], 3'b000};
                bus.wmask = 4'b0001 << cur_addr[1:0];
            end
            mem_pkg::mem_sh: begin
                bus.wdata = cur_rs2 << {cur_addr[1], 4'b0000};
                bus.wmask = cur_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                bus.wdata = cur_rs2;
                bus.wmask = 4'b1111;
            end
        endcase
    end

    // Load data comes back in wait_read, so only the held op matters
    always_comb begin
        ld_byte = bus.rdata >> {h_alu_out[1:0], 3'b000};
        ld_half = bus.rdata >> {h_alu_out[1], 4'b0000};
        case (h_mem_op)
            mem_pkg::mem_lb:  load_data = {{(mem_pkg::xlen-8){ld_byte[7]}}, ld_byte[7:0]};
            mem_pkg::mem_lbu: load_data = {{(mem_pkg::xlen-8){1'b0}}, ld_byte[7:0]};
            mem_pkg::mem_lh:  load_data = {{(mem_pkg::xlen-16){ld_half[15]}}, ld_half[15:0]};
            mem_pkg::mem_lhu: load_data = {{(mem_pkg::xlen-16){1'b0}}, ld_half[15:0]};
            default:          load_data = bus.rdata;
        endcase
    end

    assign stall        = !done;
    assign wb.valid     = done;
    assign wb.read_data = load_data;
    assign wb.reg_pc    = idle ? reg_pc : h_reg_pc;
    assign wb.alu_out   = cur_addr;
    assign wb.br_flg    = idle ? br_flg : h_br_flg;
    assign wb.br_target = idle ? br_target : h_br_target;
    assign wb.jmp_flg   = idle ? jmp_flg : h_jmp_flg;
    assign wb.rf_wen    = idle ? rf_wen : h_rf_wen;
    assign wb.wb_sel    = idle ? wb_sel : h_wb_sel;
    assign wb.wb_addr   = idle ? wb_addr : h_wb_addr;
    assign wb.ecall     = idle ? ecall : h_ecall;

endmodule

`default_nettype wire

// ==== hw/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    parameter int ram_words    = 1024,
    parameter int ready_wait   = 1,
    parameter int read_latency = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [mem_pkg::xlen-1:0] reg_pc,
    input  logic [mem_pkg::xlen-1:0] rs2_data,
    input  logic [mem_pkg::xlen-1:0] alu_out,
    input  logic                     br_flg,
    input  logic [mem_pkg::xlen-1:0] br_target,
    input  mem_pkg::mem_op_t         mem_op,
    input  logic                     rf_wen,
    input  mem_pkg::wb_sel_t         wb_sel,
    input  logic [4:0]               wb_addr,
    input  logic                     jmp_flg,
    input  logic                     ecall,
    output logic                     stall,
    output logic                     rf_we,
    output logic [4:0]               rf_waddr,
    output logic [mem_pkg::xlen-1:0] rf_wdata,
    output logic                     redirect_valid,
    output logic [mem_pkg::xlen-1:0] redirect_pc,
    output logic                     ecall_out
);
    mem_bus_if u_bus (.clk(clk));
    mem_wb_if  u_wb ();

    mem_stage u_mem_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_pc    (reg_pc),
        .rs2_data  (rs2_data),
        .alu_out   (alu_out),
        .br_target (br_target),
        .br_flg    (br_flg),
        .rf_wen    (rf_wen),
        .jmp_flg   (jmp_flg),
        .ecall     (ecall),
        .mem_op    (mem_op),
        .wb_sel    (wb_sel),
        .wb_addr   (wb_addr),
        .stall     (stall),
        .bus       (u_bus.master),
        .wb        (u_wb.source)
    );

    data_ram #(
        .ram_words    (ram_words),
        .ready_wait   (ready_wait),
        .read_latency (read_latency)
    ) u_data_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (u_bus.slave)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb             (u_wb.sink),
        .rf_we          (rf_we),
        .redirect_valid (redirect_valid),
        .ecall_out      (ecall_out),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== hw/mem_wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_wb_if;
    logic                     valid;      // Instruction leaves mem_stage this cycle
    logic [mem_pkg::xlen-1:0] reg_pc;
    logic [mem_pkg::xlen-1:0] alu_out;
    logic [mem_pkg::xlen-1:0] read_data;
    logic                     br_flg;
    logic [mem_pkg::xlen-1:0] br_target;
    logic                     jmp_flg;
    logic                     rf_wen;
    mem_pkg::wb_sel_t         wb_sel;
    logic [4:0]               wb_addr;
    logic                     ecall;

    modport source (
        output valid, reg_pc, alu_out, read_data, br_flg, br_target,
        output jmp_flg, rf_wen, wb_sel, wb_addr, ecall
    );

    modport sink (
        input  valid, reg_pc, alu_out, read_data, br_flg, br_target,
        input  jmp_flg, rf_wen, wb_sel, wb_addr, ecall
    );
endinterface

`default_nettype wire

// ==== hw/mem_wb_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  logic                     clk,
    input  logic                     rst_n,
    mem_wb_if.sink                   wb,
    output logic                     rf_we,
    output logic                     redirect_valid,
    output logic                     ecall_out,
    output logic [4:0]               rf_waddr,
    output logic [mem_pkg::xlen-1:0] rf_wdata,
    output logic [mem_pkg::xlen-1:0] redirect_pc
);
    logic [mem_pkg::xlen-1:0] wdata_sel;
    logic [mem_pkg::xlen-1:0] target_sel;

    always_comb begin
        case (wb.wb_sel)
            mem_pkg::wb_alu: wdata_sel = wb.alu_out;
            mem_pkg::wb_mem: wdata_sel = wb.read_data;
            mem_pkg::wb_pc4: wdata_sel = wb.reg_pc + mem_pkg::xlen'(4);
            default:         wdata_sel = '0;
        endcase
    end

    // Jump target is the ALU sum with bit 0 cleared
    assign target_sel = wb.br_flg ? wb.br_target : {wb.alu_out[mem_pkg::xlen-1:1], 1'b0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rf_we          <= 1'b0;
            redirect_valid <= 1'b0;
            ecall_out      <= 1'b0;
            rf_waddr       <= '0;
            rf_wdata       <= '0;
            redirect_pc    <= '0;
        end else begin
            rf_we          <= wb.valid && wb.rf_wen;   // Bubble when nothing retires
            redirect_valid <= wb.valid && (wb.br_flg || wb.jmp_flg);
            ecall_out      <= wb.valid && wb.ecall;
            rf_waddr       <= wb.wb_addr;
            rf_wdata       <= wdata_sel;
            redirect_pc    <= target_sel;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsys --Mdir obj_dir -f files.f

out=$(./obj_dir/Vtb_mem_subsys +verilator+error+limit+1000)
echo "$out"

if grep -q "Verification passed" <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== testbench/mem_stage_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     idle,
    input logic                     stall,
    input mem_pkg::mem_op_t         mem_op,
    input logic                     cmd_start,
    input logic                     cmd_write,
    input logic                     cmd_ready,
    input logic                     rdata_valid,
    input logic [mem_pkg::xlen-1:0] addr,
    input logic [mem_pkg::xlen-1:0] wdata,
    input logic [3:0]               wmask
);
    int   assert_fails = 0;
    logic rd_pending;       // Read accepted, rdata_valid not yet seen

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_pending <= 1'b0;
        else if (cmd_start && cmd_ready && !cmd_write)
            rd_pending <= 1'b1;
        else if (rdata_valid)
            rd_pending <= 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus handshake rules
    ////////////////////////////////////////////////////////////////////////////
    write_has_start: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_write |-> cmd_start) else begin
        assert_fails++;
        $error("cmd_write high without cmd_start");
    end

    request_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_start && !cmd_ready |=> $stable(addr) && $stable(wdata) && $stable(wmask))
        else begin
        assert_fails++;
        $error("Request changed while waiting for cmd_ready");
    end

    no_start_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_pending |-> !cmd_start) else begin
        assert_fails++;
        $error("cmd_start while a read is outstanding");
    end

    // Non-memory op in idle must never hold upstream
    idle_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        idle && (mem_op == mem_pkg::mem_x) |-> !stall) else begin
        assert_fails++;
        $error("stall high for mem_x in idle");
    end

endmodule

bind mem_stage mem_stage_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .idle        (idle),
    .stall       (stall),
    .mem_op      (mem_op),
    .cmd_start   (bus.cmd_start),
    .cmd_write   (bus.cmd_write),
    .cmd_ready   (bus.cmd_ready),
    .rdata_valid (bus.rdata_valid),
    .addr        (bus.addr),
    .wdata       (bus.wdata),
    .wmask       (bus.wmask)
);

`default_nettype wire

// ==== testbench/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
    localparam int xlen = mem_pkg::xlen;
    // About 310 instructions of at most 4 cycles each, with a wide margin
    localparam int max_cycles = 4000;

    typedef struct packed {
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  rs2;
        logic [xlen-1:0]  alu;
        logic [xlen-1:0]  brt;
        mem_pkg::mem_op_t op;
        mem_pkg::wb_sel_t sel;
        logic             wen;
        logic [4:0]       rd;
        logic             br;
        logic             jmp;
        logic             ec;
    } instr_t;

    logic             clk;
    logic             rst_n;
    logic [xlen-1:0]  reg_pc;
    logic [xlen-1:0]  rs2_data;
    logic [xlen-1:0]  alu_out;
    logic [xlen-1:0]  br_target;
    logic             br_flg;
    logic             rf_wen;
    logic             jmp_flg;
    logic             ecall;
    mem_pkg::mem_op_t mem_op;
    mem_pkg::wb_sel_t wb_sel;
    logic [4:0]       wb_addr;
    logic             stall;
    logic             rf_we;
    logic [4:0]       rf_waddr;
    logic [xlen-1:0]  rf_wdata;
    logic             redirect_valid;
    logic [xlen-1:0]  redirect_pc;
    logic             ecall_out;

    logic [7:0]       model_mem [4096];     // Byte image of the data RAM
    logic             pend_valid;
    logic             exp_we;
    logic [4:0]       exp_rd;
    logic [xlen-1:0]  exp_data;
    logic             exp_redir;
    logic [xlen-1:0]  exp_rpc;
    logic             exp_ec;
    logic [xlen-1:0]  pc_counter;
    string            cur_test;
    int               n_checks;
    int               n_errors;
    int               errors_at_start;
    int               cycle_count;
    int unsigned      seed;

    mem_subsys_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_pc         (reg_pc),
        .rs2_data       (rs2_data),
        .alu_out        (alu_out),
        .br_flg         (br_flg),
        .br_target      (br_target),
        .mem_op         (mem_op),
        .rf_wen         (rf_wen),
        .wb_sel         (wb_sel),
        .wb_addr        (wb_addr),
        .jmp_flg        (jmp_flg),
        .ecall          (ecall),
        .stall          (stall),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .ecall_out      (ecall_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles in test %s", max_cycles, cur_test);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [xlen-1:0] load_value(mem_pkg::mem_op_t op, logic [xlen-1:0] addr);
        logic [11:0]     a;
        logic [7:0]      b;
        logic [15:0]     h;
        logic [xlen-1:0] v;
        a = addr[11:0];
        b = model_mem[a];
        h = {model_mem[{a[11:1], 1'b1}], model_mem[{a[11:1], 1'b0}]};
        case (op)
            mem_pkg::mem_lb:  v = {{24{b[7]}}, b};
            mem_pkg::mem_lbu: v = {24'h0, b};
            mem_pkg::mem_lh:  v = {{16{h[15]}}, h};
            mem_pkg::mem_lhu: v = {16'h0, h};
            default: begin
                v = {model_mem[{a[11:2], 2'd3}], model_mem[{a[11:2], 2'd2}],
                     model_mem[{a[11:2], 2'd1}], model_mem[{a[11:2], 2'd0}]};
            end
        endcase
        return v;
    endfunction

    function automatic void store_model(mem_pkg::mem_op_t op, logic [xlen-1:0] addr,
                                        logic [xlen-1:0] data);
        logic [11:0] a;
        a = addr[11:0];
        case (op)
            mem_pkg::mem_sb: model_mem[a] = data[7:0];
            mem_pkg::mem_sh: begin
                model_mem[{a[11:1], 1'b0}] = data[7:0];
                model_mem[{a[11:1], 1'b1}] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++)
                    model_mem[{a[11:2], 2'(i)}] = data[8*i +: 8];
            end
        endcase
    endfunction

    // Expected retire values of an accepted instruction
    function automatic void predict(instr_t ins);
        pend_valid = 1'b1;
        exp_we     = ins.wen;
        exp_rd     = ins.rd;
        case (ins.sel)
            mem_pkg::wb_mem: exp_data = load_value(ins.op, ins.alu);
            mem_pkg::wb_pc4: exp_data = ins.pc + 32'd4;
            default:         exp_data = ins.alu;
        endcase
        exp_redir = ins.br || ins.jmp;
        exp_rpc   = ins.br ? ins.brt : {ins.alu[xlen-1:1], 1'b0};
        exp_ec    = ins.ec;
        if (ins.op inside {mem_pkg::mem_sb, mem_pkg::mem_sh, mem_pkg::mem_sw})
            store_model(ins.op, ins.alu, ins.rs2);
    endfunction

    function automatic instr_t idle_instr();
        instr_t ins;
        ins = '0;
        return ins;
    endfunction

    function automatic instr_t make_instr(mem_pkg::mem_op_t op, logic [xlen-1:0] alu,
                                          logic [xlen-1:0] rs2, mem_pkg::wb_sel_t sel,
                                          logic wen, logic [4:0] rd);
        instr_t ins;
        ins = '0;
        ins.pc  = pc_counter;
        ins.op  = op;
        ins.alu = alu;
        ins.rs2 = rs2;
        ins.sel = sel;
        ins.wen = wen;
        ins.rd  = rd;
        pc_counter = pc_counter + 32'd4;
        return ins;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Driving and checking
    ////////////////////////////////////////////////////////////////////////////
    task automatic check(input string what, input logic [xlen-1:0] expected,
                         input logic [xlen-1:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("ERROR %s %s: expected 0x%08h, actual 0x%08h",
                     cur_test, what, expected, actual);
        end
    endtask

    task automatic drive(input instr_t ins);
        reg_pc    <= ins.pc;
        rs2_data  <= ins.rs2;
        alu_out   <= ins.alu;
        br_target <= ins.brt;
        br_flg    <= ins.br;
        rf_wen    <= ins.wen;
        jmp_flg   <= ins.jmp;
        ecall     <= ins.ec;
        mem_op    <= ins.op;
        wb_sel    <= ins.sel;
        wb_addr   <= ins.rd;
    endtask

    // Without a pending instruction the write port must show a bubble
    task automatic check_retire();
        if (pend_valid) begin
            check("rf_we", exp_we, rf_we);
            if (exp_we) begin
                check("rf_waddr", exp_rd, rf_waddr);
                check("rf_wdata", exp_data, rf_wdata);
            end
            check("redirect_valid", exp_redir, redirect_valid);
            if (exp_redir)
                check("redirect_pc", exp_rpc, redirect_pc);
            check("ecall_out", exp_ec, ecall_out);
            pend_valid = 1'b0;
        end else begin
            check("rf_we", 0, rf_we);
            check("redirect_valid", 0, redirect_valid);
            check("ecall_out", 0, ecall_out);
        end
    endtask

    task automatic issue(input instr_t ins, output logic stalled);
        @(posedge clk);
        drive(ins);
        @(negedge clk);
        check_retire();
        stalled = 1'b0;
        while (stall) begin
            stalled = 1'b1;
            @(negedge clk);
            check_retire();
        end
        predict(ins);       // Accepted at the next rising edge
    endtask

    task automatic flush();
        @(posedge clk);
        drive(idle_instr());
        @(negedge clk);
        check_retire();
    endtask

    task automatic write_mem(input mem_pkg::mem_op_t op, input logic [xlen-1:0] addr,
                             input logic [xlen-1:0] data);
        logic st;
        issue(make_instr(op, addr, data, mem_pkg::wb_x, 1'b0, 5'd0), st);
    endtask

    task automatic read_back(input mem_pkg::mem_op_t op, input logic [xlen-1:0] addr,
                             input logic [4:0] rd, output logic stalled);
        issue(make_instr(op, addr, 0, mem_pkg::wb_mem, 1'b1, rd), stalled);
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = n_errors;
    endtask

    task automatic end_test();
        if (n_errors == errors_at_start)
            $display("%-16s ok", cur_test);
        else
            $display("%-16s FAILED with %0d mismatches", cur_test, n_errors - errors_at_start);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic fill_memory();
        logic [xlen-1:0] a;
        begin_test("fill_memory");
        for (int w = 0; w < 64; w++) begin
            a = 32'(w * 4);
            write_mem(mem_pkg::mem_sw, a, (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f);
        end
        flush();
        end_test();
    endtask

    task automatic pass_through();
        logic st;
        logic any;
        begin_test("pass_through");
        any = 1'b0;
        issue(make_instr(mem_pkg::mem_x, 32'h1234_5678, 0, mem_pkg::wb_alu, 1'b1, 5'd3), st);
        any |= st;
        issue(make_instr(mem_pkg::mem_x, 32'h0, 0, mem_pkg::wb_pc4, 1'b1, 5'd4), st);
        any |= st;
        issue(make_instr(mem_pkg::mem_x, 32'hdead_beef, 0, mem_pkg::wb_alu, 1'b0, 5'd5), st);
        any |= st;
        flush();
        check("stall seen", 0, any);
        end_test();
    endtask

    task automatic word_store_load();
        logic st;
        begin_test("word_store_load");
        write_mem(mem_pkg::mem_sw, 32'h40, 32'hcafe_f00d);
        read_back(mem_pkg::mem_lw, 32'h40, 5'd7, st);
        flush();
        check("load stall seen", 1, st);
        end_test();
    endtask

    task automatic sub_word_lanes();
        logic            st;
        logic [xlen-1:0] a;
        begin_test("sub_word_lanes");
        for (int off = 0; off < 4; off++) begin
            a = 32'h80 + 32'(off);
            write_mem(mem_pkg::mem_sw, 32'h80, 32'h1122_3344);
            write_mem(mem_pkg::mem_sb, a, 32'hffff_ff70 + 32'(off * 16));
            read_back(mem_pkg::mem_lw, 32'h80, 5'd10, st);
            read_back(mem_pkg::mem_lb, a, 5'd11, st);
            read_back(mem_pkg::mem_lbu, a, 5'd12, st);
            read_back(mem_pkg::mem_lh, {a[xlen-1:1], 1'b0}, 5'd13, st);
            read_back(mem_pkg::mem_lhu, {a[xlen-1:1], 1'b0}, 5'd14, st);
        end
        for (int off = 0; off < 4; off += 2) begin
            a = 32'h84 + 32'(off);
            write_mem(mem_pkg::mem_sw, 32'h84, 32'h5566_7788);
            write_mem(mem_pkg::mem_sh, a, 32'habcd_7ff0 + 32'(off * 32'h1000));
            read_back(mem_pkg::mem_lw, 32'h84, 5'd15, st);
            read_back(mem_pkg::mem_lh, a, 5'd16, st);
            read_back(mem_pkg::mem_lhu, a, 5'd17, st);
            read_back(mem_pkg::mem_lb, a + 32'd1, 5'd18, st);
            read_back(mem_pkg::mem_lbu, a + 32'd1, 5'd19, st);
        end
        flush();
        end_test();
    endtask

    task automatic control_flow();
        instr_t ins;
        logic   st;
        begin_test("control_flow");
        ins = make_instr(mem_pkg::mem_x, 32'h0, 0, mem_pkg::wb_x, 1'b0, 5'd0);
        ins.br  = 1'b1;
        ins.brt = 32'h0000_1000;
        issue(ins, st);
        ins = make_instr(mem_pkg::mem_x, 32'h0000_2345, 0, mem_pkg::wb_pc4, 1'b1, 5'd1);
        ins.jmp = 1'b1;     // Odd target, bit 0 must be cleared
        issue(ins, st);
        ins = make_instr(mem_pkg::mem_x, 32'h0, 0, mem_pkg::wb_x, 1'b0, 5'd0);
        ins.ec = 1'b1;
        issue(ins, st);
        issue(make_instr(mem_pkg::mem_x, 32'h77, 0, mem_pkg::wb_alu, 1'b1, 5'd2), st);
        flush();
        end_test();
    endtask

    task automatic random_stream();
        instr_t           ins;
        mem_pkg::mem_op_t op;
        mem_pkg::wb_sel_t sel;
        logic [xlen-1:0]  addr;
        logic [1:0]       low;
        logic [4:0]       rd;
        logic             st;
        int               n_stalled;
        begin_test("random_stream");
        n_stalled = 0;
        for (int i = 0; i < 200; i++) begin
            op = mem_pkg::mem_op_t'($urandom_range(0, 8));
            rd = 5'($urandom_range(1, 31));
            case (op)
                mem_pkg::mem_lb, mem_pkg::mem_lbu, mem_pkg::mem_sb: low = 2'($urandom_range(0, 3));
                mem_pkg::mem_lh, mem_pkg::mem_lhu, mem_pkg::mem_sh: low = {1'($urandom_range(0, 1)), 1'b0};
                default: low = 2'd0;
            endcase
            addr = {22'h0, 8'($urandom_range(0, 63)), low};
            if (op inside {mem_pkg::mem_sb, mem_pkg::mem_sh, mem_pkg::mem_sw}) begin
                ins = make_instr(op, addr, $urandom, mem_pkg::wb_x, 1'b0, 5'd0);
            end else if (op != mem_pkg::mem_x) begin
                ins = make_instr(op, addr, 0, mem_pkg::wb_mem, 1'b1, rd);
            end else begin
                sel = ($urandom_range(0, 1) != 0) ? mem_pkg::wb_alu : mem_pkg::wb_pc4;
                ins = make_instr(op, $urandom, 0, sel, $urandom_range(0, 3) != 0, rd);
            end
            issue(ins, st);
            if (st)
                n_stalled++;
        end
        flush();
        check("stalls observed", 1, n_stalled > 0);
        end_test();
    endtask

    initial begin
        rst_n           = 1'b0;
        pend_valid      = 1'b0;
        pc_counter      = 32'h0000_0100;
        n_checks        = 0;
        n_errors        = 0;
        errors_at_start = 0;
        cur_test        = "reset";
        drive(idle_instr());
        seed = $urandom(88613);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        fill_memory();
        pass_through();
        word_store_load();
        sub_word_lanes();
        control_flow();
        random_stream();

        if (u_dut.u_mem_stage.u_checker.assert_fails != 0) begin
            $display("Handshake checker reported %0d assertion failures",
                     u_dut.u_mem_stage.u_checker.assert_fails);
            n_errors += u_dut.u_mem_stage.u_checker.assert_fails;
        end
        $display("Checks: %0d run, %0d failed", n_checks, n_errors);
        if (n_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
